// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = tbClockTimer
FILELIST = vlog.f

OBJDIR   = obj_dir
SIMBIN   = $(OBJDIR)/V$(TOP)
SOURCES  = $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard src/*.svh)
CASES    = testbench/clockTimerCases.txt

.PHONY: all run clean

all: run

$(SIMBIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN) $(CASES)
	@out="$$(./$(SIMBIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)

// ==== src/clockTimerPkg.sv ====
package clockTimerPkg;

   // one decimal digit
   typedef logic [3:0] bcdDigit;

   // full time of day, hours tens in the top nibble
   typedef struct packed {
      bcdDigit hoursTens;
      bcdDigit hoursUnits;
      bcdDigit minTens;
      bcdDigit minUnits;
      bcdDigit secTens;
      bcdDigit secUnits;
      bcdDigit centiTens;
      bcdDigit centiUnits;
   } timeValue;

   // command FSM states
   typedef enum logic [2:0] {
      idle,
      setSec,
      setMin,
      setHour,
      showClock,
      timerRun,
      timerPaused
   } modeState;

   // segments a..g, a in bit 6, active low
   typedef logic [6:0] segPattern;

endpackage

// ==== src/clockTimerTop.sv ====
module clockTimerTop (
   input  logic                     CLK100HZ,
   input  logic                     RESETa,
   input  logic                     setSecond,
   input  logic                     setMinute,
   input  logic                     setHour,
   input  logic                     showTime,
   input  logic                     timerStart,
   input  logic                     timerPause,
   input  logic                     timerContinue,
   input  logic [7:0]               setValue,
   output logic [7:0]               anodes,
   output clockTimerPkg::segPattern segments,
   output logic                     modeClock,
   output logic                     modeTimer
);

   import clockTimerPkg::*;

   logic       centiTick;
   logic       clockRun, timerRun, timerClear, showTimer;
   logic       loadSec, loadMin, loadHour;
   logic [7:0] loadValue;
   timeValue   clockTime, timerTime;

   tickGenerator tickGen (
      .CLK100HZ (CLK100HZ),
      .RESETa   (RESETa),
      .centiTick(centiTick)
   );

   modeControl control (
      .CLK100HZ     (CLK100HZ),
      .RESETa       (RESETa),
      .setSecond    (setSecond),
      .setMinute    (setMinute),
      .setHour      (setHour),
      .showTime     (showTime),
      .timerStart   (timerStart),
      .timerPause   (timerPause),
      .timerContinue(timerContinue),
      .setValue     (setValue),
      .clockRun     (clockRun),
      .loadSec      (loadSec),
      .loadMin      (loadMin),
      .loadHour     (loadHour),
      .loadValue    (loadValue),
      .timerRun     (timerRun),
      .timerClear   (timerClear),
      .showTimer    (showTimer),
      .modeClock    (modeClock),
      .modeTimer    (modeTimer)
   );

   ////////////////////////////////////////////////////////////////////////
   // time of day is only loaded, the stopwatch is only cleared
   ////////////////////////////////////////////////////////////////////////

   timeCounter clockCount (
      .CLK100HZ (CLK100HZ),
      .RESETa   (RESETa),
      .centiTick(centiTick),
      .run      (clockRun),
      .clear    (1'b0),
      .loadSec  (loadSec),
      .loadMin  (loadMin),
      .loadHour (loadHour),
      .loadValue(loadValue),
      .timeNow  (clockTime)
   );

   timeCounter timerCount (
      .CLK100HZ (CLK100HZ),
      .RESETa   (RESETa),
      .centiTick(centiTick),
      .run      (timerRun),
      .clear    (timerClear),
      .loadSec  (1'b0),
      .loadMin  (1'b0),
      .loadHour (1'b0),
      .loadValue(8'd0),
      .timeNow  (timerTime)
   );

   displayScan scan (
      .CLK100HZ (CLK100HZ),
      .RESETa   (RESETa),
      .clockTime(clockTime),
      .timerTime(timerTime),
      .showTimer(showTimer),
      .anodes   (anodes),
      .segments (segments)
   );

endmodule

// ==== src/clockTimer_cfg.svh ====
`ifndef CLOCKTIMER_CFG_SVH
`define CLOCKTIMER_CFG_SVH

// system cycles per centisecond tick
`define TICK_DIV 4

// cycles each digit stays lit during the scan
`define SCAN_DIV 2

// digits on the display, HH MM SS CC
`define NUM_DIGITS 8

// field limits of the 24-hour clock
`define MAX_HOURS 23
`define MAX_MINSEC 59

`endif

// ==== src/displayScan.sv ====
`include "clockTimer_cfg.svh"

module displayScan (
   input  logic                     CLK100HZ,
   input  logic                     RESETa,
   input  clockTimerPkg::timeValue  clockTime,
   input  clockTimerPkg::timeValue  timerTime,
   input  logic                     showTimer,
   output logic [`NUM_DIGITS-1:0]   anodes,
   output clockTimerPkg::segPattern segments
);

   import clockTimerPkg::*;

   localparam int scanW  = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;
   localparam int digitW = $clog2(`NUM_DIGITS);
   localparam logic [scanW-1:0]  lastScan  = scanW'(`SCAN_DIV - 1);
   localparam logic [digitW-1:0] lastDigit = digitW'(`NUM_DIGITS - 1);

   logic [scanW-1:0]  scanCount;
   logic [digitW-1:0] digitIdx;
   timeValue          shownTime;
   bcdDigit           curDigit;

   function automatic segPattern segDecode(bcdDigit d);
      case (d)
         4'd0:    return 7'b0000001;
         4'd1:    return 7'b1001111;
         4'd2:    return 7'b0010010;
         4'd3:    return 7'b0000110;
         4'd4:    return 7'b1001100;
         4'd5:    return 7'b0100100;
         4'd6:    return 7'b0100000;
         4'd7:    return 7'b0001111;
         4'd8:    return 7'b0000000;
         4'd9:    return 7'b0000100;
         default: return 7'b1111111;
      endcase
   endfunction

   // digit 0 is the rightmost, centisecond units
   assign shownTime = showTimer ? timerTime : clockTime;
   assign curDigit  = shownTime[digitIdx * 4 +: 4];

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         scanCount <= '0;
         digitIdx  <= '0;
         anodes    <= '1;
         segments  <= '1;
      end else begin
         anodes   <= ~(`NUM_DIGITS'(1) << digitIdx);
         segments <= segDecode(curDigit);
         if (scanCount == lastScan) begin
            scanCount <= '0;
            digitIdx  <= (digitIdx == lastDigit) ? '0 : digitIdx + 1'b1;
         end else begin
            scanCount <= scanCount + 1'b1;
         end
      end
   end

endmodule

// ==== src/modeControl.sv ====
module modeControl (
   input  logic       CLK100HZ,
   input  logic       RESETa,
   input  logic       setSecond,
   input  logic       setMinute,
   input  logic       setHour,
   input  logic       showTime,
   input  logic       timerStart,
   input  logic       timerPause,
   input  logic       timerContinue,
   input  logic [7:0] setValue,
   output logic       clockRun,
   output logic       loadSec,
   output logic       loadMin,
   output logic       loadHour,
   output logic [7:0] loadValue,
   output logic       timerRun,
   output logic       timerClear,
   output logic       showTimer,
   output logic       modeClock,
   output logic       modeTimer
);

   import clockTimerPkg::*;

   // setHour and timerRun are also port names, so those two literals are scoped
   modeState state;
   modeState nextState;
   logic     setOk;
   logic     goSec, goMin, goHour, goShow, goStart, goPause, goContinue;

   ///////////////////////////////////////////////////////////////////////
   // command legality
   ///////////////////////////////////////////////////////////////////////

   assign setOk = (state == idle) || (state == setSec) || (state == setMin) ||
                  (state == clockTimerPkg::setHour) || (state == showClock);

   assign goSec      = setSecond && setOk;
   assign goMin      = setMinute && setOk;
   assign goHour     = setHour && setOk;
   assign goShow     = showTime;
   assign goStart    = timerStart && (state == showClock);
   assign goPause    = timerPause && (state == clockTimerPkg::timerRun);
   assign goContinue = timerContinue && (state == timerPaused);

   // first legal command in priority order wins
   always_comb begin
      nextState = state;
      if (goSec)
         nextState = setSec;
      else if (goMin)
         nextState = setMin;
      else if (goHour)
         nextState = clockTimerPkg::setHour;
      else if (goShow)
         nextState = showClock;
      else if (goStart)
         nextState = clockTimerPkg::timerRun;
      else if (goPause)
         nextState = timerPaused;
      else if (goContinue)
         nextState = clockTimerPkg::timerRun;
   end

   ///////////////////////////////////////////////////////////////////////
   // state and strobe registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         state      <= idle;
         loadSec    <= 1'b0;
         loadMin    <= 1'b0;
         loadHour   <= 1'b0;
         timerClear <= 1'b0;
      end else begin
         state      <= nextState;
         loadSec    <= goSec;
         loadMin    <= goMin && !goSec;
         loadHour   <= goHour && !goSec && !goMin;
         timerClear <= goStart && !(goSec || goMin || goHour || goShow);
      end
   end

   // value travels alongside the load strobes
   always_ff @(posedge CLK100HZ) begin
      loadValue <= setValue;
   end

   // enables follow the state directly
   assign clockRun  = (state == showClock) || (state == clockTimerPkg::timerRun) ||
                      (state == timerPaused);
   assign timerRun  = (state == clockTimerPkg::timerRun);
   assign showTimer = (state == clockTimerPkg::timerRun) || (state == timerPaused);
   assign modeClock = (state == showClock);
   assign modeTimer = showTimer;

endmodule

// ==== src/tickGenerator.sv ====
`include "clockTimer_cfg.svh"

module tickGenerator (
   input  logic CLK100HZ,
   input  logic RESETa,
   output logic centiTick
);

   localparam int cntW = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;
   localparam logic [cntW-1:0] lastCount = cntW'(`TICK_DIV - 1);

   logic [cntW-1:0] divCount;

   // free-running divider, tick follows the wrap by one cycle
   always_ff @(posedge CLK100HZ) begin
      if (RESETa) begin
         divCount  <= '0;
         centiTick <= 1'b0;
      end else begin
         centiTick <= (divCount == lastCount);
         if (divCount == lastCount)
            divCount <= '0;
         else
            divCount <= divCount + 1'b1;
      end
   end

endmodule

// ==== src/timeCounter.sv ====
`include "clockTimer_cfg.svh"

module timeCounter (
   input  logic                  CLK100HZ,
   input  logic                  RESETa,
   input  logic                  centiTick,
   input  logic                  run,
   input  logic                  clear,
   input  logic                  loadSec,
   input  logic                  loadMin,
   input  logic                  loadHour,
   input  logic [7:0]            loadValue,
   output clockTimerPkg::timeValue timeNow
);

   import clockTimerPkg::*;

   localparam bcdDigit minSecTensMax  = bcdDigit'(`MAX_MINSEC / 10);
   localparam bcdDigit minSecUnitsMax = bcdDigit'(`MAX_MINSEC % 10);
   localparam bcdDigit hoursTensMax   = bcdDigit'(`MAX_HOURS / 10);
   localparam bcdDigit hoursUnitsMax  = bcdDigit'(`MAX_HOURS % 10);

   timeValue nextTime;
   logic     carry;

   // returns {carry out, new digit}
   function automatic logic [4:0] stepDigit(bcdDigit d, bcdDigit top, logic carryIn);
      if (!carryIn)
         return {1'b0, d};
      else if (d == top)
         return {1'b1, 4'd0};
      else
         return {1'b0, d + 4'd1};
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // carry chain, one centisecond forward
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      nextTime = timeNow;
      {carry, nextTime.centiUnits} = stepDigit(timeNow.centiUnits, 4'd9, 1'b1);
      {carry, nextTime.centiTens}  = stepDigit(timeNow.centiTens, 4'd9, carry);
      {carry, nextTime.secUnits}   = stepDigit(timeNow.secUnits, minSecUnitsMax, carry);
      {carry, nextTime.secTens}    = stepDigit(timeNow.secTens, minSecTensMax, carry);
      {carry, nextTime.minUnits}   = stepDigit(timeNow.minUnits, minSecUnitsMax, carry);
      {carry, nextTime.minTens}    = stepDigit(timeNow.minTens, minSecTensMax, carry);
      // hours roll over at 23, not at 99
      if (carry) begin
         if (timeNow.hoursTens == hoursTensMax && timeNow.hoursUnits == hoursUnitsMax) begin
            nextTime.hoursTens  = '0;
            nextTime.hoursUnits = '0;
         end else begin
            {carry, nextTime.hoursUnits} = stepDigit(timeNow.hoursUnits, 4'd9, 1'b1);
            nextTime.hoursTens = timeNow.hoursTens + bcdDigit'(carry);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // time register
   ///////////////////////////////////////////////////////////////////////

   // loads split the binary value into tens and units, out of range is dropped
   always_ff @(posedge CLK100HZ) begin
      if (RESETa || clear) begin
         timeNow <= '0;
      end else if (loadSec) begin
         if (loadValue <= 8'(`MAX_MINSEC)) begin
            timeNow.secTens  <= bcdDigit'(loadValue / 8'd10);
            timeNow.secUnits <= bcdDigit'(loadValue % 8'd10);
         end
      end else if (loadMin) begin
         if (loadValue <= 8'(`MAX_MINSEC)) begin
            timeNow.minTens  <= bcdDigit'(loadValue / 8'd10);
            timeNow.minUnits <= bcdDigit'(loadValue % 8'd10);
         end
      end else if (loadHour) begin
         if (loadValue <= 8'(`MAX_HOURS)) begin
            timeNow.hoursTens  <= bcdDigit'(loadValue / 8'd10);
            timeNow.hoursUnits <= bcdDigit'(loadValue % 8'd10);
         end
      end else if (run && centiTick) begin
         timeNow <= nextTime;
      end
   end

endmodule

// ==== testbench/clockChecker.sv ====
`include "clockTimer_cfg.svh"

module clockChecker (
   input  logic                     CLK100HZ,
   input  logic [`NUM_DIGITS-1:0]   anodes,
   input  clockTimerPkg::segPattern segments,
   input  logic                     modeClock,
   input  logic                     modeTimer,
   input  logic                     checkReq,
   input  logic [7:0]               expHours,
   input  logic [7:0]               expMinutes,
   input  logic [7:0]               expSeconds,
   input  logic [1:0]               expMode,
   output bit                       checkDone,
   output int                       checkCount,
   output int                       valueErrors,
   output int                       otherErrors
);

   import clockTimerPkg::*;

   bit                     busy;
   logic [`NUM_DIGITS-1:0] seenMask;
   logic [3:0]             shown [0:`NUM_DIGITS-1];
   logic [3:0]             digit;
   int                     pos;

   // lit segments a..g with a in bit 6, so the active-low lines are inverted first
   function automatic logic [3:0] digitFromSegments(segPattern seg);
      logic [6:0] lit;
      lit = ~seg;
      case (lit)
         7'b1111110: return 4'd0;
         7'b0110000: return 4'd1;
         7'b1101101: return 4'd2;
         7'b1111001: return 4'd3;
         7'b0110011: return 4'd4;
         7'b1011011: return 4'd5;
         7'b1011111: return 4'd6;
         7'b1110000: return 4'd7;
         7'b1111111: return 4'd8;
         7'b1111011: return 4'd9;
         default:    return 4'hF;
      endcase
   endfunction

   // index of the single low anode, -1 when none or several are low
   function automatic int litPosition(logic [`NUM_DIGITS-1:0] an);
      int found;
      int lowCount;
      found    = -1;
      lowCount = 0;
      for (int k = 0; k < `NUM_DIGITS; k++) begin
         if (!an[k]) begin
            found = k;
            lowCount++;
         end
      end
      if (lowCount != 1)
         found = -1;
      return found;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // frame capture, one digit per lit anode until all are seen
   //////////////////////////////////////////////////////////////////////

   always @(posedge CLK100HZ) begin
      checkDone <= 1'b0;
      if (checkReq && !busy) begin
         busy     = 1'b1;
         seenMask = '0;
         if ({modeTimer, modeClock} != expMode) begin
            valueErrors++;
            $display("ERROR at %0t: mode outputs clock %b timer %b, expected mode %0d",
                     $time, modeClock, modeTimer, expMode);
         end
      end else if (busy) begin
         pos = litPosition(anodes);
         if (pos < 0) begin
            if (anodes != '1) begin
               otherErrors++;
               $display("anode select %b does not light exactly one digit", anodes);
            end
         end else begin
            digit = digitFromSegments(segments);
            if (digit > 4'd9) begin
               otherErrors++;
               $display("segment pattern %b on digit %0d is not a decimal digit",
                        segments, pos);
            end
            shown[pos]    = digit;
            seenMask[pos] = 1'b1;
         end
         // centiseconds move during the frame, so only HH MM SS are compared
         if (seenMask == '1) begin
            if ({shown[7], shown[6]} != expHours || {shown[5], shown[4]} != expMinutes ||
                {shown[3], shown[2]} != expSeconds) begin
               valueErrors++;
               $display("ERROR at %0t: display shows %h %h %h, expected %h %h %h", $time,
                        {shown[7], shown[6]}, {shown[5], shown[4]}, {shown[3], shown[2]},
                        expHours, expMinutes, expSeconds);
            end
            checkCount++;
            busy = 1'b0;
            checkDone <= 1'b1;
         end
      end
   end

endmodule

// ==== testbench/clockTimerCases.txt ====
// columns, all hex: command value wait check hours minutes seconds mode
// command 0 none, 1..7 setSecond setMinute setHour showTime timerStart timerPause timerContinue
// mode 0 neither, 1 clock shown, 2 stopwatch shown
0 00 0014 1 00 00 00 0   // after reset, all zero
5 00 0014 1 00 00 00 0   // start from idle is ignored
1 38 0014 1 00 00 56 0   // seconds 56
2 22 0014 1 00 34 56 0   // minutes 34
3 0C 0014 1 12 34 56 0   // hours 12
3 1E 0014 1 12 34 56 0   // hours 30 is out of range
4 00 0258 1 12 34 57 1   // 600 cycles, middle of the next second
1 3A 0014 0 00 00 00 0
2 3B 0014 0 00 00 00 0
3 17 0014 1 23 59 58 0   // clock stopped near 58.55
4 00 0492 1 00 00 01 1   // 2.95 s later, past midnight
5 00 03E8 1 00 00 02 2   // stopwatch from zero, about 2.5 s
6 00 0014 1 00 00 02 2   // frozen near 02.55
0 00 04B0 1 00 00 02 2   // three seconds on, still frozen
7 00 0168 1 00 00 03 2   // resumed, about 03.45
4 00 0064 1 00 00 08 1   // clock kept running, about 08.4
6 00 0014 1 00 00 08 1   // pause in showClock is ignored

// ==== testbench/tbClockTimer.sv ====
`include "clockTimer_cfg.svh"

module tbClockTimer;

   import clockTimerPkg::*;

   localparam int maxLines    = 64;
   localparam int lineWords   = 8;
   localparam int frameCycles = `SCAN_DIV * `NUM_DIGITS;
   localparam int resetCycles = 5;

   logic                   CLK100HZ;
   logic                   RESETa;
   logic                   setSecond;
   logic                   setMinute;
   logic                   setHour;
   logic                   showTime;
   logic                   timerStart;
   logic                   timerPause;
   logic                   timerContinue;
   logic [7:0]             setValue;
   logic [`NUM_DIGITS-1:0] anodes;
   segPattern              segments;
   logic                   modeClock;
   logic                   modeTimer;

   logic       checkReq;
   logic [7:0] expHours;
   logic [7:0] expMinutes;
   logic [7:0] expSeconds;
   logic [1:0] expMode;
   bit         checkDone;
   int         checkCount;
   int         valueErrors;
   int         otherErrors;

   logic [15:0] caseWords [0:maxLines*lineWords-1];
   int          lineCount;
   int          checkLines;
   int          caseErrors;
   int          cycleCount;
   int          cycleLimit;

   clockTimerTop clockTimerTop_inst (
      .CLK100HZ     (CLK100HZ),
      .RESETa       (RESETa),
      .setSecond    (setSecond),
      .setMinute    (setMinute),
      .setHour      (setHour),
      .showTime     (showTime),
      .timerStart   (timerStart),
      .timerPause   (timerPause),
      .timerContinue(timerContinue),
      .setValue     (setValue),
      .anodes       (anodes),
      .segments     (segments),
      .modeClock    (modeClock),
      .modeTimer    (modeTimer)
   );

   clockChecker displayCheck (
      .CLK100HZ   (CLK100HZ),
      .anodes     (anodes),
      .segments   (segments),
      .modeClock  (modeClock),
      .modeTimer  (modeTimer),
      .checkReq   (checkReq),
      .expHours   (expHours),
      .expMinutes (expMinutes),
      .expSeconds (expSeconds),
      .expMode    (expMode),
      .checkDone  (checkDone),
      .checkCount (checkCount),
      .valueErrors(valueErrors),
      .otherErrors(otherErrors)
   );

   always #5 CLK100HZ = ~CLK100HZ;

   // command codes 1..7 follow the strobe priority order
   task automatic driveCommand(input logic [15:0] code, input logic level);
      case (code)
         16'd1:   setSecond <= level;
         16'd2:   setMinute <= level;
         16'd3:   setHour <= level;
         16'd4:   showTime <= level;
         16'd5:   timerStart <= level;
         16'd6:   timerPause <= level;
         16'd7:   timerContinue <= level;
         default: ;
      endcase
   endtask

   task automatic runCase(input int n);
      logic [15:0] cmd;
      logic [15:0] waitCycles;
      int          base;
      base       = n * lineWords;
      cmd        = caseWords[base];
      waitCycles = caseWords[base + 2];
      @(posedge CLK100HZ);
      driveCommand(cmd, 1'b1);
      setValue <= caseWords[base + 1][7:0];
      @(posedge CLK100HZ);
      driveCommand(cmd, 1'b0);
      repeat (waitCycles) @(posedge CLK100HZ);
      if (caseWords[base + 3] != 16'h0) begin
         expHours   <= caseWords[base + 4][7:0];
         expMinutes <= caseWords[base + 5][7:0];
         expSeconds <= caseWords[base + 6][7:0];
         expMode    <= caseWords[base + 7][1:0];
         checkReq   <= 1'b1;
         @(posedge CLK100HZ);
         checkReq <= 1'b0;
         while (!checkDone)
            @(posedge CLK100HZ);
      end
   endtask

   task closeRun(input logic timedOut);
      $display("checks %0d, value errors %0d, other errors %0d, timed out %0d",
               checkCount, valueErrors, otherErrors + caseErrors, timedOut);
      if (!timedOut && valueErrors == 0 && otherErrors == 0 && caseErrors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   endtask

   //////////////////////////////////////////////////////////////////////
   // cycle limit
   //////////////////////////////////////////////////////////////////////

   always @(posedge CLK100HZ) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("timeout, the cases did not finish within %0d cycles", cycleLimit);
         closeRun(1'b1);
      end
   end

   initial begin
      int waitSum;
      CLK100HZ      = 1'b0;
      RESETa        = 1'b1;
      setSecond     = 1'b0;
      setMinute     = 1'b0;
      setHour       = 1'b0;
      showTime      = 1'b0;
      timerStart    = 1'b0;
      timerPause    = 1'b0;
      timerContinue = 1'b0;
      setValue      = 8'd0;
      checkReq      = 1'b0;
      expHours      = 8'h00;
      expMinutes    = 8'h00;
      expSeconds    = 8'h00;
      expMode       = 2'd0;
      cycleLimit    = 0;
      // words the file does not reach keep F in the top digit
      for (int i = 0; i < maxLines * lineWords; i++)
         caseWords[i] = 16'hF000 | 16'(i);
      $readmemh("testbench/clockTimerCases.txt", caseWords);

      waitSum = 0;
      while (lineCount < maxLines && caseWords[lineCount * lineWords][15:12] != 4'hF) begin
         waitSum += int'(caseWords[lineCount * lineWords + 2]);
         if (caseWords[lineCount * lineWords + 3] != 16'h0)
            checkLines++;
         if (caseWords[lineCount * lineWords] > 16'd7) begin
            $display("case line %0d has an unknown command code", lineCount);
            caseErrors++;
         end
         lineCount++;
      end
      if (lineCount == 0) begin
         $display("no cases found in testbench/clockTimerCases.txt");
         caseErrors++;
      end
      // two strobe cycles per line and at most two frames per check
      cycleLimit = resetCycles + waitSum + 2 * lineCount + 2 * frameCycles * checkLines + 200;

      repeat (resetCycles) @(posedge CLK100HZ);
      RESETa <= 1'b0;
      for (int n = 0; n < lineCount; n++)
         runCase(n);
      closeRun(1'b0);
   end

endmodule

// ==== vlog.f ====
+incdir+src
src/clockTimerPkg.sv
src/tickGenerator.sv
src/timeCounter.sv
src/modeControl.sv
src/displayScan.sv
src/clockTimerTop.sv
testbench/clockChecker.sv
testbench/tbClockTimer.sv
